//--- hw/plca_pkg.sv
package plca_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // MII data nibble
    localparam int NIBBLE_W = 4;
    // node ids, node count and cur_id
    localparam int NODE_ID_W = 8;

    // control codes on RXD/TXD, sent with the error line set and data valid clear
    localparam logic [NIBBLE_W-1:0] BEACON_CODE = 4'b0010;
    localparam logic [NIBBLE_W-1:0] COMMIT_CODE = 4'b0011;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        RX_NONE   = 2'd0,
        RX_BEACON = 2'd1,
        RX_COMMIT = 2'd2
    } rx_cmd_e;

    // one registered snapshot of the receive pins
    typedef struct packed {
        rx_cmd_e cmd;
        // RX_DV or a COMMIT on the line
        logic    receiving;
        logic    crs;
    } rx_info_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        TX_IDLE   = 2'd0,
        TX_BEACON = 2'd1,
        TX_DATA   = 2'd2
    } tx_cmd_e;

    // controller output, valid every cycle
    typedef struct packed {
        tx_cmd_e                cmd;
        logic [NODE_ID_W-1:0]   cur_id;
        // own opportunity with a frame to send
        logic                   own;
    } txop_t;

    // one delay line entry
    typedef struct packed {
        logic [NIBBLE_W-1:0] data;
        logic                last;
    } frame_nibble_t;

    // transmit pin group
    typedef struct packed {
        logic [NIBBLE_W-1:0] txd;
        logic                tx_en;
        logic                tx_er;
    } mii_tx_t;

endpackage

//--- hw/plca_rx_decode.sv
`timescale 1ns/1ps

module plca_rx_decode (
    input  logic                          TX_CLK,
    input  logic                          rst_n,
    input  logic [plca_pkg::NIBBLE_W-1:0] RXD,
    input  logic                          RX_DV,
    input  logic                          RX_ER,
    input  logic                          CRS,
    output plca_pkg::rx_info_t            rx_info
);

    // classification of the raw pins
    plca_pkg::rx_cmd_e cmd_d;

    // control codes only count with RX_ER set and RX_DV clear
    // reserved codes fall through to none
    always_comb
    begin
        cmd_d = plca_pkg::RX_NONE;
        if (!RX_DV && RX_ER)
        begin
            if (RXD == plca_pkg::BEACON_CODE)
            begin
                cmd_d = plca_pkg::RX_BEACON;
            end
            else if (RXD == plca_pkg::COMMIT_CODE)
            begin
                cmd_d = plca_pkg::RX_COMMIT;
            end
        end
    end

    // one register stage, later stages never look at the pins
    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n)
        begin
            rx_info <= '0;
        end
        else
        begin
            rx_info.cmd       <= cmd_d;
            // a COMMIT holds the medium like a frame does
            rx_info.receiving <= RX_DV || (cmd_d == plca_pkg::RX_COMMIT);
            rx_info.crs       <= CRS;
        end
    end

endmodule

//--- hw/plca_txop_ctrl.sv
`timescale 1ns/1ps

module plca_txop_ctrl #(
    parameter int BEACON_CYCLES = 20,
    parameter int TO_CYCLES     = 32
) (
    input  logic                           TX_CLK,
    input  logic                           rst_n,
    input  logic                           plca_en,
    input  logic [plca_pkg::NODE_ID_W-1:0] node_id,
    input  logic [plca_pkg::NODE_ID_W-1:0] node_count,
    input  plca_pkg::rx_info_t             rx_info,
    input  logic                           frame_ready,
    input  plca_pkg::frame_nibble_t        head,
    output plca_pkg::txop_t                txop,
    output logic                           pop,
    output logic                           beacon_sent
);

    // one timer serves as beacon timer and opportunity timer
    localparam int TMR_MAX = (BEACON_CYCLES > TO_CYCLES) ? BEACON_CYCLES : TO_CYCLES;
    localparam int TMR_W   = $clog2(TMR_MAX + 1);

    typedef enum logic [1:0] {
        DISABLED    = 2'd0,
        BEACON      = 2'd1,
        WAIT_BEACON = 2'd2,
        OPPORTUNITY = 2'd3
    } state_e;

    state_e                         state;
    logic [TMR_W-1:0]               timer;
    logic [plca_pkg::NODE_ID_W-1:0] cur_id;
    // another node is using the current opportunity
    logic                           rx_seen;
    // follower has seen the beacon start
    logic                           bcn_seen;

    logic coord;
    logic own;
    logic to_done;
    logic rx_done;
    logic own_done;
    logic advance;
    logic last_id;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opportunity decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // node 0 is the coordinator
    assign coord = (node_id == '0);

    // own opportunity, only if nobody else has grabbed it
    assign own      = (state == OPPORTUNITY) && (cur_id == node_id) && frame_ready && !rx_seen;
    assign pop      = own;
    assign own_done = own && head.last;

    // silent timeout, held off while the line is busy
    assign to_done = (timer == TMR_W'(TO_CYCLES - 1)) && !rx_seen && !rx_info.receiving && !own;
    // the other node's transmission just ended
    assign rx_done = rx_seen && !rx_info.receiving;
    assign advance = (state == OPPORTUNITY) && (to_done || rx_done || own_done);

    // cur_id is the last one of the cycle, 9 bits to avoid the wrap at 255
    assign last_id = ({1'b0, cur_id} + 9'd1) >= {1'b0, node_count};

    // last beacon cycle
    assign beacon_sent = (state == BEACON) && (timer == TMR_W'(BEACON_CYCLES - 1));

    always_comb
    begin
        txop.cmd = plca_pkg::TX_IDLE;
        if (state == BEACON)
        begin
            txop.cmd = plca_pkg::TX_BEACON;
        end
        else if (own)
        begin
            txop.cmd = plca_pkg::TX_DATA;
        end
        txop.cur_id = cur_id;
        txop.own    = own;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n || !plca_en)
        begin
            state    <= DISABLED;
            timer    <= '0;
            cur_id   <= '0;
            rx_seen  <= 1'b0;
            bcn_seen <= 1'b0;
        end
        else
        begin
            case (state)
                DISABLED:
                begin
                    timer  <= '0;
                    cur_id <= '0;
                    state  <= coord ? BEACON : WAIT_BEACON;
                end
                BEACON:
                begin
                    // BEACON_CYCLES cycles, then opportunity 0
                    if (beacon_sent)
                    begin
                        state   <= OPPORTUNITY;
                        timer   <= '0;
                        cur_id  <= '0;
                        rx_seen <= 1'b0;
                    end
                    else
                    begin
                        timer <= timer + 1'b1;
                    end
                end
                WAIT_BEACON:
                begin
                    if (coord)
                    begin
                        // node id changed to 0 while running
                        state <= BEACON;
                        timer <= '0;
                    end
                    else if (rx_info.cmd == plca_pkg::RX_BEACON)
                    begin
                        bcn_seen <= 1'b1;
                    end
                    else if (bcn_seen)
                    begin
                        // beacon over, opportunity 0 starts
                        bcn_seen <= 1'b0;
                        state    <= OPPORTUNITY;
                        timer    <= '0;
                        cur_id   <= '0;
                        rx_seen  <= 1'b0;
                    end
                end
                OPPORTUNITY:
                begin
                    if (!coord && (rx_info.cmd == plca_pkg::RX_BEACON))
                    begin
                        // early beacon, resync to the coordinator
                        state    <= WAIT_BEACON;
                        bcn_seen <= 1'b1;
                    end
                    else if (advance)
                    begin
                        timer   <= '0;
                        rx_seen <= 1'b0;
                        if (last_id)
                        begin
                            cur_id <= '0;
                            state  <= coord ? BEACON : WAIT_BEACON;
                        end
                        else
                        begin
                            cur_id <= cur_id + 1'b1;
                        end
                    end
                    else
                    begin
                        if (rx_info.receiving)
                        begin
                            rx_seen <= 1'b1;
                        end
                        // timer frozen while sending or receiving
                        if (!own && !rx_info.receiving && !rx_seen)
                        begin
                            timer <= timer + 1'b1;
                        end
                    end
                end
                default:
                begin
                    state <= DISABLED;
                end
            endcase
        end
    end

endmodule

//--- hw/plca_delay_line.sv
`timescale 1ns/1ps

module plca_delay_line #(
    parameter int DELAY_DEPTH = 128
) (
    input  logic                          TX_CLK,
    input  logic                          rst_n,
    input  logic [plca_pkg::NIBBLE_W-1:0] mac_txd,
    input  logic                          mac_txen,
    input  logic                          pop,
    output plca_pkg::frame_nibble_t       head,
    output logic                          frame_ready,
    output logic                          mac_defer
);

    localparam int AW = $clog2(DELAY_DEPTH);

    plca_pkg::frame_nibble_t mem [DELAY_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // address of the most recent write
    logic [AW-1:0] wr_last;
    logic          txen_q;
    logic          frame_end;

    // circular increment, depth need not be a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        logic [AW-1:0] n;
        n = (p == AW'(DELAY_DEPTH - 1)) ? '0 : p + 1'b1;
        return n;
    endfunction

    // mac_txen falling, the previous nibble closed the frame
    assign frame_end = txen_q && !mac_txen;

    // head is the oldest stored nibble
    assign head = mem[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge TX_CLK)
    begin
        if (mac_txen)
        begin
            mem[wr_ptr].data <= mac_txd;
            mem[wr_ptr].last <= 1'b0;
            wr_last          <= wr_ptr;
        end
        else if (frame_end)
        begin
            // tag the final nibble once the end is known
            mem[wr_last].last <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            txen_q      <= 1'b0;
            frame_ready <= 1'b0;
            mac_defer   <= 1'b0;
        end
        else
        begin
            txen_q <= mac_txen;
            if (mac_txen)
            begin
                wr_ptr    <= ptr_inc(wr_ptr);
                // hold off the MAC until this frame has drained
                mac_defer <= 1'b1;
            end
            // whole frame stored, last tag lands on the same edge
            if (frame_end)
            begin
                frame_ready <= 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= ptr_inc(rd_ptr);
                if (head.last)
                begin
                    frame_ready <= 1'b0;
                    mac_defer   <= 1'b0;
                end
            end
        end
    end

endmodule

//--- hw/plca_tx_mux.sv
`timescale 1ns/1ps

module plca_tx_mux (
    input  logic                    TX_CLK,
    input  logic                    rst_n,
    input  plca_pkg::txop_t         txop,
    input  plca_pkg::frame_nibble_t head,
    output plca_pkg::mii_tx_t       mii_tx
);

    // next value of the pins
    plca_pkg::mii_tx_t mii_d;

    always_comb
    begin
        mii_d = '0;
        case (txop.cmd)
            plca_pkg::TX_BEACON:
            begin
                // beacon is a control code, TX_ER high and TX_EN low
                mii_d.txd   = plca_pkg::BEACON_CODE;
                mii_d.tx_er = 1'b1;
            end
            plca_pkg::TX_DATA:
            begin
                // frame nibble popped on this same cycle
                mii_d.txd   = head.data;
                mii_d.tx_en = 1'b1;
            end
            default:
            begin
                // idle, all zero
                mii_d = '0;
            end
        endcase
    end

    // pins come straight from flops
    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n)
        begin
            mii_tx <= '0;
        end
        else
        begin
            mii_tx <= mii_d;
        end
    end

endmodule

//--- hw/plca_status_mon.sv
`timescale 1ns/1ps

module plca_status_mon #(
    parameter int STATUS_TIMEOUT = 400
) (
    input  logic               TX_CLK,
    input  logic               rst_n,
    input  logic               plca_en,
    input  plca_pkg::rx_info_t rx_info,
    input  logic               beacon_sent,
    output logic               plca_status
);

    localparam int CNT_W = $clog2(STATUS_TIMEOUT + 1);

    // cycles since the last beacon
    logic [CNT_W-1:0] wd_cnt;
    logic             beacon_evt;

    // either our own beacon or one heard on the line
    assign beacon_evt = beacon_sent || (rx_info.cmd == plca_pkg::RX_BEACON);

    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n || !plca_en)
        begin
            plca_status <= 1'b0;
            wd_cnt      <= '0;
        end
        else if (beacon_evt)
        begin
            // OK, restart the watchdog
            plca_status <= 1'b1;
            wd_cnt      <= '0;
        end
        else if (wd_cnt == CNT_W'(STATUS_TIMEOUT - 1))
        begin
            // FAIL, counter parks here until the next beacon
            plca_status <= 1'b0;
        end
        else
        begin
            wd_cnt <= wd_cnt + 1'b1;
        end
    end

endmodule

//--- hw/plca_rs_top.sv
`timescale 1ns/1ps

module plca_rs_top #(
    parameter int BEACON_CYCLES  = 20,
    parameter int TO_CYCLES      = 32,
    parameter int DELAY_DEPTH    = 128,
    parameter int STATUS_TIMEOUT = 400
) (
    input  logic                           TX_CLK,
    input  logic                           rst_n,
    // configuration
    input  logic                           plca_en,
    input  logic [plca_pkg::NODE_ID_W-1:0] node_id,
    input  logic [plca_pkg::NODE_ID_W-1:0] node_count,
    // receive MII, taken as synchronous to TX_CLK
    input  logic [plca_pkg::NIBBLE_W-1:0]  RXD,
    input  logic                           RX_DV,
    input  logic                           RX_ER,
    input  logic                           CRS,
    // MAC side
    input  logic [plca_pkg::NIBBLE_W-1:0]  mac_txd,
    input  logic                           mac_txen,
    // transmit MII
    output logic [plca_pkg::NIBBLE_W-1:0]  TXD,
    output logic                           TX_EN,
    output logic                           TX_ER,
    output logic                           mac_defer,
    output logic                           plca_status
);

    plca_pkg::rx_info_t      rx_info;
    plca_pkg::txop_t         txop;
    plca_pkg::frame_nibble_t head;
    plca_pkg::mii_tx_t       mii_tx;
    logic                    pop;
    logic                    frame_ready;
    logic                    beacon_sent;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1, receive decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    plca_rx_decode rx_decode_i (
        .TX_CLK  (TX_CLK),
        .rst_n   (rst_n),
        .RXD     (RXD),
        .RX_DV   (RX_DV),
        .RX_ER   (RX_ER),
        .CRS     (CRS),
        .rx_info (rx_info)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 2, opportunity control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    plca_txop_ctrl #(
        .BEACON_CYCLES (BEACON_CYCLES),
        .TO_CYCLES     (TO_CYCLES)
    ) txop_ctrl_i (
        .TX_CLK      (TX_CLK),
        .rst_n       (rst_n),
        .plca_en     (plca_en),
        .node_id     (node_id),
        .node_count  (node_count),
        .rx_info     (rx_info),
        .frame_ready (frame_ready),
        .head        (head),
        .txop        (txop),
        .pop         (pop),
        .beacon_sent (beacon_sent)
    );

    // frame buffer between MAC and opportunity
    plca_delay_line #(
        .DELAY_DEPTH (DELAY_DEPTH)
    ) delay_line_i (
        .TX_CLK      (TX_CLK),
        .rst_n       (rst_n),
        .mac_txd     (mac_txd),
        .mac_txen    (mac_txen),
        .pop         (pop),
        .head        (head),
        .frame_ready (frame_ready),
        .mac_defer   (mac_defer)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 3, transmit pins and status
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    plca_tx_mux tx_mux_i (
        .TX_CLK (TX_CLK),
        .rst_n  (rst_n),
        .txop   (txop),
        .head   (head),
        .mii_tx (mii_tx)
    );

    plca_status_mon #(
        .STATUS_TIMEOUT (STATUS_TIMEOUT)
    ) status_mon_i (
        .TX_CLK      (TX_CLK),
        .rst_n       (rst_n),
        .plca_en     (plca_en),
        .rx_info     (rx_info),
        .beacon_sent (beacon_sent),
        .plca_status (plca_status)
    );

    // pin group back onto the MII names
    assign TXD   = mii_tx.txd;
    assign TX_EN = mii_tx.tx_en;
    assign TX_ER = mii_tx.tx_er;

endmodule

//--- dv/plca_rs_tb.sv
`timescale 1ns/1ps

module plca_rs_tb;

    localparam int BEACON_CYCLES = 20;
    localparam int TO_CYCLES     = 32;
    localparam int SEED          = 24017;
    // control code of a beacon on the MII
    localparam logic [3:0] BEACON_NIBBLE = 4'b0010;

    // one trace line, the name is kept apart
    typedef struct packed {
        int node_id;
        int node_count;
        int frame_len;
        int rx_at;
        int rx_len;
        int cycles;
        int exp_beacon;
        int exp_min;
        int exp_max;
        int exp_txen;
        int exp_status;
        int exp_defer;
    } test_t;

    logic       TX_CLK;
    logic       rst_n;
    logic       plca_en;
    logic [7:0] node_id;
    logic [7:0] node_count;
    logic [3:0] RXD;
    logic       RX_DV;
    logic       RX_ER;
    logic       CRS;
    logic [3:0] mac_txd;
    logic       mac_txen;
    logic [3:0] TXD;
    logic       TX_EN;
    logic       TX_ER;
    logic       mac_defer;
    logic       plca_status;

    string      names[$];
    test_t      tests[$];
    // nibbles of the frame under test, in MAC order
    logic [3:0] frame[$];
    int         cycle_limit;
    logic       limit_ready;
    int         test_errors;
    int         total_errors;
    int         failed_tests;

    plca_rs_top dut_i (
        .TX_CLK      (TX_CLK),
        .rst_n       (rst_n),
        .plca_en     (plca_en),
        .node_id     (node_id),
        .node_count  (node_count),
        .RXD         (RXD),
        .RX_DV       (RX_DV),
        .RX_ER       (RX_ER),
        .CRS         (CRS),
        .mac_txd     (mac_txd),
        .mac_txen    (mac_txen),
        .TXD         (TXD),
        .TX_EN       (TX_EN),
        .TX_ER       (TX_ER),
        .mac_defer   (mac_defer),
        .plca_status (plca_status)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        TX_CLK = 1'b0;
        forever #5 TX_CLK = ~TX_CLK;
    end

    // run limit is the sum of the per-test budgets
    initial
    begin : watchdog
        int wd_cycles;
        wd_cycles = 0;
        wait (limit_ready);
        while (wd_cycles < cycle_limit)
        begin
            @(posedge TX_CLK);
            wd_cycles++;
        end
        $display("timeout: tests still running after %0d cycles", wd_cycles);
        $display("Done: errors found");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one clock, inputs change 1 ns after the edge
    task automatic step();
        @(posedge TX_CLK);
        #1;
    endtask

    task automatic report_error(input string msg);
        $display("error: time %0t: %s", $time, msg);
        test_errors++;
    endtask

    task automatic read_trace(output int ok);
        int    fd;
        int    n;
        string line;
        string name;
        test_t t;
        ok = 1;
        fd = $fopen("dv/plca_rs_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file dv/plca_rs_trace.txt");
            ok = 0;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                // comment and blank lines hold no test
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d", name,
                                t.node_id, t.node_count, t.frame_len, t.rx_at, t.rx_len,
                                t.cycles, t.exp_beacon, t.exp_min, t.exp_max, t.exp_txen,
                                t.exp_status, t.exp_defer);
                    if (n != 13)
                    begin
                        $display("trace line could not be parsed: %s", line);
                        ok = 0;
                    end
                    else
                    begin
                        names.push_back(name);
                        tests.push_back(t);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // all transmit outputs quiet
    task automatic check_idle_pins(input string where);
        assert (TX_EN == 1'b0) else report_error($sformatf("TX_EN high %s", where));
        assert (TX_ER == 1'b0) else report_error($sformatf("TX_ER high %s", where));
        assert (TXD == 4'h0) else report_error($sformatf("TXD is %h %s", TXD, where));
        assert (mac_defer == 1'b0) else report_error($sformatf("mac_defer high %s", where));
        assert (plca_status == 1'b0) else report_error($sformatf("plca_status high %s", where));
    endtask

    task automatic apply_reset(input test_t t);
        rst_n      = 1'b0;
        plca_en    = 1'b0;
        node_id    = 8'(t.node_id);
        node_count = 8'(t.node_count);
        RXD        = 4'h0;
        RX_DV      = 1'b0;
        RX_ER      = 1'b0;
        CRS        = 1'b0;
        mac_txd    = 4'h0;
        mac_txen   = 1'b0;
        repeat (8) step();
        check_idle_pins("in reset");
        rst_n = 1'b1;
        step();
        check_idle_pins("after reset");
    endtask

    // MAC writes one frame of random nibbles into the delay line
    task automatic load_frame(input int len);
        int k;
        frame.delete();
        for (k = 0; k < len; k++)
        begin
            frame.push_back(4'($urandom()));
            mac_txen = 1'b1;
            mac_txd  = frame[k];
            step();
        end
        mac_txen = 1'b0;
        mac_txd  = 4'h0;
        step();
        step();
        if (len > 0)
        begin
            assert (mac_defer == 1'b1) else report_error("mac_defer low with a frame stored");
        end
    endtask

    // beacon from the coordinator on the receive pins
    task automatic send_rx_beacon();
        int k;
        for (k = 0; k < BEACON_CYCLES; k++)
        begin
            RXD   = BEACON_NIBBLE;
            RX_ER = 1'b1;
            CRS   = 1'b1;
            step();
        end
        RXD   = 4'h0;
        RX_ER = 1'b0;
        CRS   = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one scenario from the trace
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_test(input string name, input test_t t);
        int   i;
        int   gap;
        int   first_bcn;
        int   bcn_run;
        int   first_txen;
        int   txen_count;
        int   txen_runs;
        logic prev_txen;
        logic status_seen;
        test_errors = 0;
        apply_reset(t);
        // random idle gap before the MAC starts
        gap = $urandom_range(3, 0);
        repeat (gap) step();
        load_frame(t.frame_len);
        plca_en = 1'b1;
        // window counts from plca_en for node 0, from the beacon end otherwise
        if (t.node_id != 0)
        begin
            send_rx_beacon();
        end
        first_bcn   = 0;
        bcn_run     = 0;
        first_txen  = -1;
        txen_count  = 0;
        txen_runs   = 0;
        prev_txen   = 1'b0;
        status_seen = 1'b0;
        for (i = 1; i <= t.cycles; i++)
        begin
            step();
            // length of the first complete beacon on the pins
            if (TX_ER && !TX_EN && TXD == BEACON_NIBBLE)
            begin
                bcn_run++;
            end
            else
            begin
                if (bcn_run > 0 && first_bcn == 0)
                begin
                    first_bcn = bcn_run;
                end
                bcn_run = 0;
            end
            if (TX_EN)
            begin
                if (!prev_txen)
                begin
                    txen_runs++;
                end
                if (first_txen < 0)
                begin
                    first_txen = i;
                end
                // nibbles leave in MAC order
                if (txen_count < t.frame_len)
                begin
                    assert (TXD == frame[txen_count])
                    else report_error($sformatf("nibble %0d is %h, expected %h",
                                                txen_count, TXD, frame[txen_count]));
                end
                txen_count++;
            end
            prev_txen   = TX_EN;
            status_seen = status_seen | plca_status;
            // another node holds the medium during this window
            RX_DV = (t.rx_len > 0) && (i >= t.rx_at) && (i < t.rx_at + t.rx_len);
            CRS   = RX_DV;
        end
        RX_DV = 1'b0;
        CRS   = 1'b0;
        assert (first_bcn == t.exp_beacon)
        else report_error($sformatf("beacon ran %0d cycles, expected %0d", first_bcn,
                                    t.exp_beacon));
        assert (txen_count == t.exp_txen)
        else report_error($sformatf("TX_EN high %0d cycles, expected %0d", txen_count,
                                    t.exp_txen));
        if (t.exp_txen > 0)
        begin
            assert (txen_runs == 1)
            else report_error($sformatf("frame split into %0d TX_EN runs", txen_runs));
            assert (first_txen >= t.exp_min && first_txen <= t.exp_max)
            else report_error($sformatf("first TX_EN at cycle %0d, window %0d..%0d",
                                        first_txen, t.exp_min, t.exp_max));
        end
        assert (status_seen == 1'b1) else report_error("plca_status never went high");
        assert (int'(plca_status) == t.exp_status)
        else report_error($sformatf("plca_status is %0b at the end", plca_status));
        assert (int'(mac_defer) == t.exp_defer)
        else report_error($sformatf("mac_defer is %0b at the end", mac_defer));
        if (test_errors != 0)
        begin
            failed_tests++;
        end
        total_errors += test_errors;
        $display("test %-12s %s, %0d error(s)", name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin : main
        int ok;
        int k;
        rst_n        = 1'b0;
        plca_en      = 1'b0;
        node_id      = 8'h0;
        node_count   = 8'h0;
        RXD          = 4'h0;
        RX_DV        = 1'b0;
        RX_ER        = 1'b0;
        CRS          = 1'b0;
        mac_txd      = 4'h0;
        mac_txen     = 1'b0;
        limit_ready  = 1'b0;
        cycle_limit  = 0;
        total_errors = 0;
        failed_tests = 0;
        void'($urandom(SEED));
        read_trace(ok);
        if (ok == 0 || tests.size() == 0)
        begin
            $display("no usable tests in the trace file");
            total_errors++;
        end
        else
        begin
            // budget per test: full cycle, beacon, frame and slack
            for (k = 0; k < tests.size(); k++)
            begin
                cycle_limit += tests[k].node_count * TO_CYCLES + BEACON_CYCLES
                               + tests[k].frame_len + 50;
            end
            limit_ready = 1'b1;
            for (k = 0; k < tests.size(); k++)
            begin
                run_test(names[k], tests[k]);
            end
        end
        $display("tests %0d, failed %0d, errors %0d", tests.size(), failed_tests,
                 total_errors);
        if (total_errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- dv/plca_rs_trace.txt
# name node_id node_count frame_len rx_at rx_len cycles exp_beacon exp_min exp_max exp_txen exp_status exp_defer
# cycles count from plca_en on node 0, else from the end of the received beacon
# rx_at/rx_len place an RX_DV pulse in the window, rx_len 0 means no pulse
# exp_min/exp_max bound the first TX_EN cycle, exp_txen is the TX_EN cycle count
#
# coordinator, beacon then its own frame in opportunity 0
coord_n4      0  4  16  0  0   80 20  20  56 16 1 0
coord_n2      0  2  60  0  0  110 20  20  56 60 1 0
#
# followers after a received beacon, silent opportunities before their own
follow_k1     1  3  40  0  0  110  0  32  68 40 1 0
follow_k2     2  4  24  0  0  110  0  64 100 24 1 0
follow_k3     3  5  30  0  0  140  0  96 132 30 1 0
#
# RX_DV held at the end of opportunity 0 delays the own opportunity
rx_hold_k2    2  4  24 32 20  130  0  84 120 24 1 0
rx_hold_k3    3  4   8 32 10  150  0 106 142  8 1 0
#
# node id outside node_count, one beacon then silence until the status drops
status_fail  20 16  12  0  0  450  0   0   0  0 0 1

//--- plca_rs.f
hw/plca_pkg.sv
hw/plca_rx_decode.sv
hw/plca_txop_ctrl.sv
hw/plca_delay_line.sv
hw/plca_tx_mux.sv
hw/plca_status_mon.sv
hw/plca_rs_top.sv
dv/plca_rs_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the PLCA RS testbench with Verilator, from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        -f plca_rs.f --top-module plca_rs_tb -Mdir obj_dir -o plca_rs_sim \
    && ./obj_dir/plca_rs_sim | tee /dev/stderr | grep -qF "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
